/* sim.f */
verilog/fb_pkg.sv
verilog/cmd_decode.sv
verilog/draw_engine.sv
verilog/frame_ram.sv
verilog/scan_out.sv
verilog/fb_top.sv
bench/tb_fb_top.sv

/* Makefile */
TOP := tb_fb_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run into sim.log, look for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fb_top import fb_pkg::*; ();

  //////////////////////////////////////////////////////////////////////
  // run length budget
  //////////////////////////////////////////////////////////////////////

  localparam int n_scans  = 5;                          // one per test
  localparam int n_cmds   = 90;                         // 40 plot, 40 span, 10 illegal
  localparam int scan_ns  = 40 * (3 * fb_w * fb_h + 100);
  localparam int cmd_ns   = 40 * 200;
  localparam int limit_ns = n_scans * scan_ns + n_cmds * cmd_ns + 40 * 2000;

  logic           clka = 1'b0;
  logic           rst;
  logic           cmd_valid;
  cmd_word_u      cmd_word;
  logic           busy;
  logic           cmd_error;
  logic           frame_start;
  logic           pix_valid;
  logic [x_w-1:0] pix_x;
  logic [y_w-1:0] pix_y;
  rgb_t           pix_rgb;
  logic           frame_done;

  int             seed;
  logic [7:0]     model_mem [fb_bytes];   // expected frame, byte per address

  always #20 clka = ~clka;   // 40 ns period

  fb_top u_fb_top (
    .clka, .rst, .cmd_valid, .cmd_word, .busy, .cmd_error,
    .frame_start, .pix_valid, .pix_x, .pix_y, .pix_rgb, .frame_done
  );

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_pixel(input string name,
      input logic [x_w-1:0] exp_x, input logic [y_w-1:0] exp_y, input rgb_t exp_rgb,
      input logic [x_w-1:0] act_x, input logic [y_w-1:0] act_y, input rgb_t act_rgb);
    if (exp_x !== act_x || exp_y !== act_y || exp_rgb !== act_rgb)
      fail_run($sformatf("mismatch %s: expected (%0d,%0d) %06h, actual (%0d,%0d) %06h",
                         name, exp_x, exp_y, exp_rgb, act_x, act_y, act_rgb));
  endtask

  task automatic check_strobe(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v)
      fail_run($sformatf("mismatch %s: expected %b, actual %b", name, exp_v, act_v));
  endtask

  task automatic check_count(input string name, input int exp_n, input int act_n);
    if (exp_n != act_n)
      fail_run($sformatf("mismatch %s: expected %0d, actual %0d", name, exp_n, act_n));
  endtask

  //////////////////////////////////////////////////////////////////////
  // frame model
  //////////////////////////////////////////////////////////////////////

  // red disk over cyan disk over green/blue halves
  function automatic rgb_t image_rule(input int x, input int y);
    int d_red;
    int d_cyan;
    d_red  = (x - red_cx) * (x - red_cx) + (y - red_cy) * (y - red_cy);
    d_cyan = (x - cyan_cx) * (x - cyan_cx) + (y - cyan_cy) * (y - cyan_cy);
    if (d_red <= red_r2)
      return '{r: 8'd255, g: 8'd0, b: 8'd0};
    if (d_cyan <= cyan_r2)
      return '{r: 8'd0, g: 8'd255, b: 8'd255};
    if (x < half_x)
      return '{r: 8'd0, g: 8'd255, b: 8'd0};
    return '{r: 8'd0, g: 8'd0, b: 8'd255};
  endfunction

  function automatic logic [7:0] nib_expand(input logic [3:0] n);
    return 8'(int'(n) * 17);
  endfunction

  task automatic model_put(input int x, input int y, input rgb_t c);
    int a;
    a = (x + y * fb_w) * 3;   // red byte first
    model_mem[a]     = c.r;
    model_mem[a + 1] = c.g;
    model_mem[a + 2] = c.b;
  endtask

  function automatic rgb_t model_pixel(input int x, input int y);
    int a;
    a = (x + y * fb_w) * 3;
    return '{r: model_mem[a], g: model_mem[a + 1], b: model_mem[a + 2]};
  endfunction

  task automatic model_reset();
    for (int yy = 0; yy < fb_h; yy++)
      for (int xx = 0; xx < fb_w; xx++)
        model_put(xx, yy, image_rule(xx, yy));
  endtask

  //////////////////////////////////////////////////////////////////////
  // drivers, all called at a falling edge
  //////////////////////////////////////////////////////////////////////

  // legal command, busy must last 3 cycles per pixel plus one
  task automatic send_cmd(input string name, input cmd_word_u cw, input int n_px);
    int busy_cyc;
    busy_cyc  = 0;
    cmd_word  = cw;
    cmd_valid = 1'b1;
    @(negedge clka);
    cmd_valid = 1'b0;
    while (busy === 1'b1) begin
      busy_cyc++;
      check_strobe({name, " cmd_error"}, 1'b0, cmd_error);
      if (busy_cyc > 200)
        fail_run($sformatf("%s: busy never dropped", name));
      @(negedge clka);
    end
    check_count({name, " busy cycles"}, 3 * n_px + 1, busy_cyc);
  endtask

  // exactly one error strobe, busy stays low
  task automatic send_illegal(input string name, input cmd_word_u cw);
    cmd_word  = cw;
    cmd_valid = 1'b1;
    @(negedge clka);
    cmd_valid = 1'b0;
    check_strobe({name, " cmd_error"}, 1'b1, cmd_error);
    repeat (4) begin
      check_strobe({name, " busy"}, 1'b0, busy);
      @(negedge clka);
      check_strobe({name, " cmd_error again"}, 1'b0, cmd_error);
    end
  endtask

  // whole frame against the model; restart_at pulses frame_start mid-scan
  task automatic scan_frame(input string name, input int restart_at);
    int cyc;
    int idx;
    int ex;
    int ey;
    cyc         = 0;
    idx         = 0;
    frame_start = 1'b1;
    while (idx < fb_w * fb_h) begin
      @(negedge clka);
      cyc++;
      frame_start = (cyc == restart_at);
      if (cyc > 3 * fb_w * fb_h + 100)
        fail_run($sformatf("%s: scan stalled after %0d pixels", name, idx));
      if (pix_valid === 1'b1) begin
        ex = idx % fb_w;
        ey = idx / fb_w;
        check_count({name, " pixel cycle"}, 4 + 3 * idx, cyc);   // first at 4, then every 3
        check_pixel(name, x_w'(ex), y_w'(ey), model_pixel(ex, ey), pix_x, pix_y, pix_rgb);
        check_strobe({name, " frame_done"}, idx == fb_w * fb_h - 1, frame_done);
        idx++;
      end else begin
        check_strobe({name, " frame_done early"}, 1'b0, frame_done);
      end
    end
    frame_start = 1'b0;
    @(negedge clka);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic plot_test();
    cmd_word_u   cw;
    logic [31:0] r;
    for (int i = 0; i < 40; i++) begin
      r             = $random(seed);
      cw            = '0;
      cw.plot.op    = op_plot;
      cw.plot.x     = r[5:0];
      cw.plot.y     = y_w'(int'(r[11:6]) % fb_h);   // keep on screen
      cw.plot.rsvd  = r[17:12];                      // junk, must be ignored
      cw.plot.r_n   = r[21:18];
      cw.plot.g_n   = r[25:22];
      cw.plot.b_n   = r[29:26];
      model_put(int'(cw.plot.x), int'(cw.plot.y),
                '{r: nib_expand(cw.plot.r_n), g: nib_expand(cw.plot.g_n),
                  b: nib_expand(cw.plot.b_n)});
      send_cmd($sformatf("plot %0d", i), cw, 1);
    end
    scan_frame("plot scan", -1);
  endtask

  task automatic span_test();
    cmd_word_u   cw;
    logic [31:0] r;
    rgb_t        c;
    int          n_px;
    for (int i = 0; i < 40; i++) begin
      r           = $random(seed);
      cw          = '0;
      cw.span.op  = op_span;
      cw.span.x0  = x_w'(40 + int'(r[4:0]) % 24);   // near the right edge
      cw.span.len = r[10:5];
      cw.span.y   = y_w'(int'(r[16:11]) % fb_h);
      cw.span.r_n = r[20:17];
      cw.span.g_n = r[24:21];
      cw.span.b_n = r[28:25];
      c = '{r: nib_expand(cw.span.r_n), g: nib_expand(cw.span.g_n),
            b: nib_expand(cw.span.b_n)};
      n_px = 0;
      for (int k = 0; k <= int'(cw.span.len); k++) begin
        if (int'(cw.span.x0) + k < fb_w) begin   // clipped at the row end
          model_put(int'(cw.span.x0) + k, int'(cw.span.y), c);
          n_px++;
        end
      end
      send_cmd($sformatf("span %0d", i), cw, n_px);
    end
    scan_frame("span scan", -1);
  endtask

  task automatic illegal_test();
    cmd_word_u   cw;
    logic [31:0] r;
    for (int i = 0; i < 10; i++) begin
      r          = $random(seed);
      cw         = r;
      cw.plot.op = (i % 2 == 0) ? 2'b00 : 2'b11;
      send_illegal($sformatf("illegal %0d", i), cw);
    end
    scan_frame("illegal scan", -1);   // frame untouched
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 10744;
    rst         = 1'b1;
    cmd_valid   = 1'b0;
    cmd_word    = '0;
    frame_start = 1'b0;
    model_reset();
    repeat (10) @(negedge clka);
    rst = 1'b0;
    check_strobe("reset busy", 1'b0, busy);
    check_strobe("reset cmd_error", 1'b0, cmd_error);
    check_strobe("reset pix_valid", 1'b0, pix_valid);
    check_strobe("reset frame_done", 1'b0, frame_done);

    scan_frame("power-up scan", -1);
    plot_test();
    span_test();
    illegal_test();
    scan_frame("cadence scan", 1500);   // second start lands mid-frame

    $display("** PASS **");
    $finish;
  end

  initial begin
    #(limit_ns);
    fail_run("watchdog: the run took longer than the test budget allows");
  end

endmodule

`default_nettype wire

/* verilog/fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_top import fb_pkg::*; (
  input  wire logic        clka,
  input  wire logic        rst,
  input  wire logic        cmd_valid,
  input  wire cmd_word_u   cmd_word,
  output logic             busy,
  output logic             cmd_error,
  input  wire logic        frame_start,
  output logic             pix_valid,
  output logic [x_w-1:0]   pix_x,
  output logic [y_w-1:0]   pix_y,
  output rgb_t             pix_rgb,
  output logic             frame_done
);

  // decoder to engine
  logic              go;
  logic              is_span;
  logic [x_w-1:0]    x0;
  logic [y_w-1:0]    y;
  logic [x_w-1:0]    len;
  rgb_t              color;
  logic              draw_done;

  // ram ports
  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic [7:0]        wr_data;
  logic [addr_w-1:0] rd_addr;
  logic [7:0]        rd_data;

  cmd_decode u_cmd_decode (
    .clka, .rst, .cmd_valid, .cmd_word, .draw_done,
    .busy, .cmd_error, .go, .is_span, .x0, .y, .len, .color
  );

  draw_engine u_draw_engine (
    .clka, .rst, .go, .is_span, .x0, .y, .len, .color,
    .draw_done, .wr_en, .wr_addr, .wr_data
  );

  frame_ram u_frame_ram (
    .clka, .wr_en, .wr_addr, .wr_data, .rd_addr, .rd_data
  );

  scan_out u_scan_out (
    .clka, .rst, .frame_start, .rd_data,
    .rd_addr, .pix_valid, .pix_x, .pix_y, .pix_rgb, .frame_done
  );

endmodule

`default_nettype wire

/* verilog/scan_out.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_out import fb_pkg::*; (
  input  wire logic          clka,
  input  wire logic          rst,
  input  wire logic          frame_start,
  input  wire logic [7:0]    rd_data,
  output logic [addr_w-1:0]  rd_addr,
  output logic               pix_valid,
  output logic [x_w-1:0]     pix_x,
  output logic [y_w-1:0]     pix_y,
  output rgb_t               pix_rgb,
  output logic               frame_done
);

  logic              scan_busy;   // start to frame_done
  logic              fetching;    // addresses 1..last going out
  logic [addr_w-1:0] addr_q;
  logic              start_ok;
  logic              rd_vld;      // rd_data valid this cycle
  logic [1:0]        ch;
  logic [7:0]        r_hold;
  logic [7:0]        g_hold;
  logic [x_w-1:0]    cx;
  logic [y_w-1:0]    cy;
  logic              last_px;

  assign start_ok = frame_start && !scan_busy;   // ignored mid-scan
  assign rd_addr  = fetching ? addr_q : '0;      // byte 0 sits ready when idle
  assign last_px  = (cx == x_w'(fb_w - 1)) && (cy == y_w'(fb_h - 1));

  //////////////////////////////////////////////////////////////////////
  // address side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clka) begin
    if (rst) begin
      fetching <= 1'b0;
      rd_vld   <= 1'b0;
    end else begin
      rd_vld <= start_ok || fetching;
      if (start_ok) begin
        fetching <= 1'b1;
        addr_q   <= addr_w'(1);    // byte 0 read in the start cycle
      end else if (fetching) begin
        addr_q <= addr_q + 1'b1;
        if (addr_q == addr_w'(fb_bytes - 1))
          fetching <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data side with three bytes per pixel
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clka) begin
    if (rst) begin
      scan_busy  <= 1'b0;
      pix_valid  <= 1'b0;
      frame_done <= 1'b0;
      ch         <= 2'd0;
    end else begin
      pix_valid  <= 1'b0;
      frame_done <= 1'b0;
      if (start_ok) begin
        scan_busy <= 1'b1;
        ch        <= 2'd0;
        cx        <= '0;
        cy        <= '0;
      end else if (rd_vld) begin
        case (ch)
          2'd0: r_hold <= rd_data;
          2'd1: g_hold <= rd_data;
          default: begin
            pix_rgb    <= '{r: r_hold, g: g_hold, b: rd_data};
            pix_valid  <= 1'b1;
            pix_x      <= cx;
            pix_y      <= cy;
            frame_done <= last_px;
            if (last_px)
              scan_busy <= 1'b0;   // new start accepted from here
            if (cx == x_w'(fb_w - 1)) begin
              cx <= '0;
              cy <= cy + 1'b1;
            end else begin
              cx <= cx + 1'b1;
            end
          end
        endcase
        ch <= (ch == 2'd2) ? 2'd0 : ch + 2'd1;
      end
    end
  end

  a_pix_gap: assert property (@(posedge clka) disable iff (rst)
    pix_valid |-> !$past(pix_valid) && !$past(pix_valid, 2))
    else $error("pixels closer than three cycles");

endmodule

`default_nettype wire

/* verilog/frame_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_ram import fb_pkg::*; (
  input  wire logic              clka,
  input  wire logic              wr_en,
  input  wire logic [addr_w-1:0] wr_addr,
  input  wire logic [7:0]        wr_data,
  input  wire logic [addr_w-1:0] rd_addr,
  output logic [7:0]             rd_data
);

  logic [7:0] mem [fb_bytes];

  // port a, write only
  always_ff @(posedge clka) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // port b, one cycle read
  always_ff @(posedge clka) begin
    rd_data <= mem[rd_addr];
  end

  ////////////////////////////////////////////////////////////////////
  // power-up test image
  ////////////////////////////////////////////////////////////////////

  initial begin
    rgb_t p;
    int   a;
    for (int yy = 0; yy < fb_h; yy++) begin
      for (int xx = 0; xx < fb_w; xx++) begin
        p = test_pixel(xx, yy);
        a = (xx + yy * fb_w) * 3;   // red byte
        mem[a]     = p.r;
        mem[a + 1] = p.g;
        mem[a + 2] = p.b;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/draw_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module draw_engine import fb_pkg::*; (
  input  wire logic              clka,
  input  wire logic              rst,
  input  wire logic              go,
  input  wire logic              is_span,
  input  wire logic [x_w-1:0]    x0,
  input  wire logic [y_w-1:0]    y,
  input  wire logic [x_w-1:0]    len,
  input  wire rgb_t              color,
  output logic                   draw_done,
  output logic                   wr_en,
  output logic [addr_w-1:0]      wr_addr,
  output logic [7:0]             wr_data
);

  //////////////////////////////////////////////////////////////////////
  // span setup, computed once per command
  //////////////////////////////////////////////////////////////////////

  logic [addr_w-1:0] pix_idx;
  logic [addr_w-1:0] start_addr;
  logic [x_w:0]      span_px;   // requested pixels, 1..64
  logic [x_w:0]      edge_px;   // room left on the row
  logic [x_w:0]      n_px;

  assign pix_idx    = addr_w'(y) * addr_w'(fb_w) + addr_w'(x0);
  assign start_addr = pix_idx * addr_w'(3);             // red byte of first pixel
  assign span_px    = is_span ? ({1'b0, len} + 1'b1) : (x_w + 1)'(1);
  assign edge_px    = (x_w + 1)'(fb_w) - {1'b0, x0};
  assign n_px       = (span_px < edge_px) ? span_px : edge_px;  // clip, no wrap

  //////////////////////////////////////////////////////////////////////
  // byte stepping
  //////////////////////////////////////////////////////////////////////

  logic [1:0]   chan;       // 0 r, 1 g, 2 b
  logic [1:0]   chan_nx;
  logic [x_w:0] pix_left;   // pixels after the current one
  logic [7:0]   nx_byte;

  assign chan_nx = (chan == 2'd2) ? 2'd0 : chan + 2'd1;

  always_comb begin
    case (chan_nx)
      2'd0:    nx_byte = color.r;
      2'd1:    nx_byte = color.g;
      default: nx_byte = color.b;
    endcase
  end

  always_ff @(posedge clka) begin
    if (rst) begin
      wr_en     <= 1'b0;
      draw_done <= 1'b0;
      chan      <= 2'd0;
    end else begin
      draw_done <= 1'b0;
      if (go) begin
        wr_en <= 1'b1;    // first write next cycle
        chan  <= 2'd0;
      end else if (wr_en) begin
        if (chan == 2'd2 && pix_left == '0) begin
          wr_en <= 1'b0;  // last byte written this cycle
        end else begin
          chan <= chan_nx;
          // flag the last write as it goes out
          draw_done <= (chan == 2'd1) && (pix_left == '0);
        end
      end
    end
  end

  // address, data and pixel count
  always_ff @(posedge clka) begin
    if (go) begin
      wr_addr  <= start_addr;
      wr_data  <= color.r;
      pix_left <= n_px - 1'b1;
    end else if (wr_en) begin
      wr_addr <= wr_addr + 1'b1;   // bytes are contiguous along a row
      wr_data <= nx_byte;
      if (chan == 2'd2)
        pix_left <= pix_left - 1'b1;
    end
  end

  a_addr_range: assert property (@(posedge clka) disable iff (rst)
    wr_en |-> (wr_addr < addr_w'(fb_bytes)))
    else $error("write past end of frame");

  a_no_go_busy: assert property (@(posedge clka) disable iff (rst) go |-> !wr_en)
    else $error("go while drawing");

endmodule

`default_nettype wire

/* verilog/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode import fb_pkg::*; (
  input  wire logic           clka,
  input  wire logic           rst,
  input  wire logic           cmd_valid,
  input  wire cmd_word_u      cmd_word,
  input  wire logic           draw_done,
  output logic                busy,
  output logic                cmd_error,
  output logic                go,
  output logic                is_span,
  output logic [x_w-1:0]      x0,
  output logic [y_w-1:0]      y,
  output logic [x_w-1:0]      len,
  output rgb_t                color
);

  logic accept;  // idle and strobed
  logic legal;

  assign accept = cmd_valid && !busy;
  assign legal  = (cmd_word.plot.op == op_plot) || (cmd_word.plot.op == op_span);

  // control
  always_ff @(posedge clka) begin
    if (rst) begin
      busy      <= 1'b0;
      go        <= 1'b0;
      cmd_error <= 1'b0;
    end else begin
      go        <= 1'b0;
      cmd_error <= 1'b0;
      if (draw_done)
        busy <= 1'b0;   // free again next cycle
      if (accept) begin
        if (legal) begin
          go   <= 1'b1;
          busy <= 1'b1;
        end else begin
          cmd_error <= 1'b1;  // nothing drawn and busy untouched
        end
      end
    end
  end

  // command fields held while busy
  always_ff @(posedge clka) begin
    if (accept && legal) begin
      if (cmd_word.span.op == op_span) begin
        is_span <= 1'b1;
        x0      <= cmd_word.span.x0;
        y       <= cmd_word.span.y;
        len     <= cmd_word.span.len;
        color   <= '{r: nib_to_byte(cmd_word.span.r_n),
                     g: nib_to_byte(cmd_word.span.g_n),
                     b: nib_to_byte(cmd_word.span.b_n)};
      end else begin
        is_span <= 1'b0;
        x0      <= cmd_word.plot.x;
        y       <= cmd_word.plot.y;
        len     <= '0;              // single pixel
        color   <= '{r: nib_to_byte(cmd_word.plot.r_n),
                     g: nib_to_byte(cmd_word.plot.g_n),
                     b: nib_to_byte(cmd_word.plot.b_n)};
      end
    end
  end

  // the engine only finishes a command that was accepted
  a_done_busy: assert property (@(posedge clka) disable iff (rst) draw_done |-> busy)
    else $error("draw_done while idle");

endmodule

`default_nettype wire

/* verilog/fb_pkg.sv */
`default_nettype none

package fb_pkg;

  ////////////////////////////////////////////////////////////////////
  // frame geometry
  ////////////////////////////////////////////////////////////////////

  localparam int fb_w     = 64;           // pixels per line
  localparam int fb_h     = 48;           // lines per frame
  localparam int fb_bytes = fb_w * fb_h * 3;  // r,g,b per pixel
  localparam int addr_w   = 14;           // covers fb_bytes
  localparam int x_w      = 6;
  localparam int y_w      = 6;

  // opcodes, 00 and 11 illegal
  localparam logic [1:0] op_plot = 2'b01;
  localparam logic [1:0] op_span = 2'b10;

  // power-up image, disk rule
  localparam int red_cx  = 32;
  localparam int red_cy  = 24;
  localparam int red_r2  = 75;
  localparam int cyan_cx = 52;
  localparam int cyan_cy = 34;
  localparam int cyan_r2 = 40;
  localparam int half_x  = 32;            // green left of this, blue right

  ////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  // one command word, two readings picked by op
  typedef union packed {
    struct packed {
      logic [1:0]     op;
      logic [x_w-1:0] x;
      logic [y_w-1:0] y;
      logic [5:0]     rsvd;   // ignored
      logic [3:0]     r_n;
      logic [3:0]     g_n;
      logic [3:0]     b_n;
    } plot;
    struct packed {
      logic [1:0]     op;
      logic [x_w-1:0] x0;
      logic [y_w-1:0] y;
      logic [x_w-1:0] len;    // pixels minus one
      logic [3:0]     r_n;
      logic [3:0]     g_n;
      logic [3:0]     b_n;
    } span;
  } cmd_word_u;

  // nibble repeated, n*17
  function automatic logic [7:0] nib_to_byte(input logic [3:0] n);
    return {n, n};
  endfunction

  // test image colour at (x,y)
  function automatic rgb_t test_pixel(input int x, input int y);
    rgb_t p;
    if ((x - red_cx) * (x - red_cx) + (y - red_cy) * (y - red_cy) <= red_r2)
      p = '{r: 8'hff, g: 8'h00, b: 8'h00};
    else if ((x - cyan_cx) * (x - cyan_cx) + (y - cyan_cy) * (y - cyan_cy) <= cyan_r2)
      p = '{r: 8'h00, g: 8'hff, b: 8'hff};
    else if (x < half_x)
      p = '{r: 8'h00, g: 8'hff, b: 8'h00};
    else
      p = '{r: 8'h00, g: 8'h00, b: 8'hff};
    return p;
  endfunction

endpackage

`default_nettype wire
